// File: rtl/uart_cmd_defines.svh
`ifndef UART_CMD_DEFINES_SVH
`define UART_CMD_DEFINES_SVH

// Defaults for a 50 MHz clock at 115200 baud
// A build that predefines the guard macro supplies its own values instead

// Clock cycles per serial bit
`define UART_CLKS_PER_BIT 434

// Idle cycles on tx between the two frames of a command
`define UART_GAP_CYCLES 100

// Start, 8 data, parity, stop
`define UART_FRAME_BITS 11

`endif

// File: rtl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // One serial payload byte
  typedef logic [7:0] uart_byte_t;

  // Host command from bit 15 down to bit 0
  typedef struct packed {
    logic       write;   // Set for write, clear for read
    logic [6:0] addr;
    uart_byte_t wdata;   // Ignored on reads
  } cmd_t;

  // One received reply frame
  typedef struct packed {
    uart_byte_t data;
    logic       parity_ok;   // Odd parity matched
    logic       stop_ok;     // Stop bit sampled high
  } rx_result_t;

endpackage

// File: rtl/uart_tx_serializer.sv
`timescale 1ns/1ps
`include "uart_cmd_defines.svh"

module uart_tx_serializer
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 parity, 10 stop
  uart_byte_t       shift_q;
  logic             par_q;
  logic             bit_end;

  assign bit_end = busy && (clk_cnt == CNT_W'(CPB - 1));
  assign tx_done = bit_end && (bit_idx == 4'(`UART_FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;   // Line idles high
    end
    else if (tx_start)
    begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;   // Start bit
    end
    else if (busy)
    begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      if (bit_end)
      begin
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx < 4'd8)
          tx <= shift_q[0];
        else if (bit_idx == 4'd8)
          tx <= par_q;
        else
          tx <= 1'b1;   // Stop bit, then idle
        if (tx_done)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_start)
    begin
      shift_q <= tx_byte;
      par_q   <= ~^tx_byte;   // Odd parity
    end
    else if (bit_end && bit_idx < 4'd8)
      shift_q <= shift_q >> 1;
  end

  // Controller must wait for tx_done before the next byte
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !busy
  );

endmodule

// File: rtl/uart_rx_deserializer.sv
`timescale 1ns/1ps
`include "uart_cmd_defines.svh"

module uart_rx_deserializer
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_arm,
  output logic       rx_valid,
  output rx_result_t rx_result
);

  localparam int CPB      = `UART_CLKS_PER_BIT;
  localparam int HALF     = CPB / 2;
  localparam int CNT_W    = $clog2(CPB);
  localparam int PAR_IDX  = `UART_FRAME_BITS - 2;
  localparam int STOP_IDX = `UART_FRAME_BITS - 1;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;   // Edge register
  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  uart_byte_t       data_q;
  logic             par_q;
  logic             start_edge;
  logic             mid_bit;
  logic             bit_end;

  assign start_edge = rx_arm && !busy && rx_prev && !rx_sync;
  assign mid_bit    = busy && (clk_cnt == CNT_W'(HALF - 1));
  assign bit_end    = clk_cnt == CNT_W'(CPB - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (start_edge)
      begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
      else if (busy)
      begin
        clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
        if (bit_end)
          bit_idx <= bit_idx + 1'b1;
        if (mid_bit && bit_idx == 4'd0 && rx_sync)
          busy <= 1'b0;   // Glitch, not a start bit
        if (mid_bit && bit_idx == 4'(STOP_IDX))
        begin
          busy     <= 1'b0;
          rx_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid_bit)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        data_q <= {rx_sync, data_q[7:1]};   // LSB first
      if (bit_idx == 4'(PAR_IDX))
        par_q <= rx_sync;
      if (bit_idx == 4'(STOP_IDX))
      begin
        rx_result.data      <= data_q;
        rx_result.parity_ok <= ^{data_q, par_q};   // Odd count of ones
        rx_result.stop_ok   <= rx_sync;
      end
    end
  end

  a_valid_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
  );

endmodule

// File: rtl/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`include "uart_cmd_defines.svh"

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic       tx_start,
  output logic [7:0] tx_byte,
  input  logic       tx_done,
  output logic       rx_arm,
  input  logic       rx_valid,
  input  rx_result_t rx_result,
  output logic [7:0] read_data,
  output logic       read_rdy,
  output logic       read_err
);

  localparam int GAP_W = $clog2(`UART_GAP_CYCLES + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_LO,
    S_GAP,
    S_SEND_HI,
    S_WAIT_RX
  } state_t;

  state_t           state;
  cmd_t             cmd_q;
  logic [GAP_W-1:0] gap_cnt;
  logic             accept;
  logic             reply_ok;

  assign accept   = cmd_vld && cmd_rdy;
  assign reply_ok = rx_result.parity_ok && rx_result.stop_ok;
  assign rx_arm   = (state == S_WAIT_RX);

  // Second frame carries write flag and address
  assign tx_byte = (state == S_SEND_HI) ? {cmd_q.write, cmd_q.addr} : cmd_q.wdata;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        S_IDLE:
          if (accept)
          begin
            state    <= S_SEND_LO;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;   // First frame one cycle after accept
          end
        S_SEND_LO:
          if (tx_done)
          begin
            state   <= S_GAP;
            gap_cnt <= GAP_W'(`UART_GAP_CYCLES - 1);
          end
        S_GAP:
          if (gap_cnt == GAP_W'(1))
          begin
            state    <= S_SEND_HI;
            tx_start <= 1'b1;   // Lands GAP cycles after tx_done
          end
          else
            gap_cnt <= gap_cnt - 1'b1;
        S_SEND_HI:
          if (tx_done)
          begin
            if (cmd_q.write)
            begin
              state   <= S_IDLE;
              cmd_rdy <= 1'b1;
            end
            else
              state <= S_WAIT_RX;
          end
        S_WAIT_RX:
          if (rx_valid)
          begin
            state    <= S_IDLE;
            cmd_rdy  <= 1'b1;
            read_rdy <= reply_ok;
            read_err <= !reply_ok;
          end
        default:
        begin
          state   <= S_IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (state == S_WAIT_RX && rx_valid)
      read_data <= rx_result.data;
  end

  a_rdy_err_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(read_rdy && read_err)
  );

  a_rdy_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rdy == (state == S_IDLE)
  );

endmodule

// File: rtl/uart_cmd_top.sv
`timescale 1ns/1ps
`include "uart_cmd_defines.svh"

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       rx,
  output logic       tx,
  output logic [7:0] read_data,
  output logic       read_rdy,
  output logic       read_err
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_done;
  logic       rx_arm;
  logic       rx_valid;
  rx_result_t rx_result;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_valid  (rx_valid),
    .rx_result (rx_result),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_serializer u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_deserializer u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

endmodule

// File: verif/tb_uart_line_tasks.svh
`ifndef TB_UART_LINE_TASKS_SVH
`define TB_UART_LINE_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  check_count++;
  if (expected !== actual)
  begin
    error_count++;
    $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
  end
endtask

// Decodes one tx frame with samples on the falling clock near mid-bit
task automatic decode_tx_frame(output logic [7:0] data, output logic par,
                               output logic stop, output time start_t);
  int i;
  @(negedge tx);
  start_t = $time;
  repeat (CPB / 2) @(negedge clk);
  check_value("tx start bit", 0, tx);
  for (i = 0; i < 8; i++)
  begin
    repeat (CPB) @(negedge clk);
    data[i] = tx;   // LSB first
  end
  repeat (CPB) @(negedge clk);
  par = tx;
  repeat (CPB) @(negedge clk);
  stop = tx;
endtask

task automatic check_frame(input string which, input logic [7:0] expected,
                           input logic [7:0] data, input logic par, input logic stop);
  check_value({which, " data"}, expected, data);
  check_value({which, " parity"}, 1, ^{data, par});   // Ones count must be odd
  check_value({which, " stop"}, 1, stop);
endtask

// Caller is 1 ns past a rising edge
task automatic drive_rx_frame(input logic [7:0] data, input bit bad_par);
  logic [10:0] bits;
  int i;
  bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
  for (i = 0; i < FRAME; i++)
  begin
    rx = bits[i];
    repeat (CPB) @(posedge clk);
    #1;
  end
endtask

task automatic check_line_idle(input int cycles);
  int lows;
  lows = 0;
  repeat (cycles)
  begin
    @(negedge clk);
    if (!tx)
      lows++;
  end
  check_value("tx low cycles after command", 0, lows);
endtask

`endif

// File: verif/tb_uart_cmd.sv
`timescale 1ns/1ps
`include "uart_cmd_defines.svh"

module tb_uart_cmd
  import uart_cmd_pkg::*;
();

  localparam int CPB         = `UART_CLKS_PER_BIT;
  localparam int GAP         = `UART_GAP_CYCLES;
  localparam int FRAME       = `UART_FRAME_BITS;
  localparam int PERIOD      = 4;
  localparam int NUM_WRITES  = 20;
  localparam int NUM_READS   = 20;
  localparam int NUM_CMDS    = NUM_WRITES + NUM_READS + 3;
  localparam int MARGIN_BITS = 400;
  localparam longint WATCHDOG_NS =
    longint'(NUM_CMDS * (3 * FRAME * CPB + GAP) + MARGIN_BITS * CPB) * PERIOD;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic [7:0] read_data;
  logic       read_rdy;
  logic       read_err;

  integer     seed;
  int         check_count;
  int         error_count;
  int         rdy_pulses;
  int         err_pulses;
  logic [7:0] last_read;

  `include "tb_uart_line_tasks.svh"

  uart_cmd_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk)
  begin
    if (read_rdy)
    begin
      rdy_pulses++;
      last_read = read_data;
    end
    if (read_err)
      err_pulses++;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  task automatic issue_command(input cmd_t c);
    @(posedge clk);
    #1;
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  task automatic wait_until_ready();
    do
      @(negedge clk);
    while (!cmd_rdy);
    @(posedge clk);   // Lets the pulse counters settle
    #1;
  endtask

  // Pulses cmd_vld while the master is busy, once mid-frame and once in the gap
  task automatic pulse_ignored(input cmd_t c);
    int k;
    for (k = 0; k < 2; k++)
    begin
      repeat (k == 0 ? 4 * CPB : 7 * CPB + GAP / 2) @(posedge clk);
      #1;
      check_value("cmd_rdy at ignored command", 0, cmd_rdy);
      cmd_in  = c;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
    end
  endtask

  task automatic do_command(input cmd_t c, input logic [7:0] reply, input bit bad_par,
                            input bit inject, output int gap);
    int         rdy0;
    int         err0;
    logic [7:0] b;
    logic       p;
    logic       s;
    time        t1;
    time        t2;
    rdy0 = rdy_pulses;
    err0 = err_pulses;
    issue_command(c);
    fork
      begin
        decode_tx_frame(b, p, s, t1);
        check_frame("tx low byte", c[7:0], b, p, s);
        decode_tx_frame(b, p, s, t2);
        check_frame("tx high byte", c[15:8], b, p, s);
      end
      if (inject)
        pulse_ignored(cmd_t'(~c));
    join
    gap = int'((t2 - t1) / PERIOD) - FRAME * CPB;
    if (!c.write)
    begin
      repeat (CPB) @(posedge clk);   // Second frame fully done
      #1;
      drive_rx_frame(reply, bad_par);
    end
    wait_until_ready();
    if (c.write)
      check_line_idle(FRAME * CPB);
    check_value("read_rdy pulses", !c.write && !bad_par, rdy_pulses - rdy0);
    check_value("read_err pulses", !c.write && bad_par, err_pulses - err0);
    if (!c.write && !bad_par)
      check_value("read_data", reply, last_read);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before)
      $display("Test %s: pass", name);
    else
      $display("Test %s: FAIL, %0d errors", name, error_count - errors_before);
  endtask

  initial
  begin
    int          errs;
    int          gap;
    logic [31:0] r;
    cmd_t        c;
    seed        = 51;
    check_count = 0;
    error_count = 0;
    rdy_pulses  = 0;
    err_pulses  = 0;
    last_read   = '0;
    rst_n       = 1'b0;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    rx          = 1'b1;   // Idle line
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    errs = error_count;
    check_value("tx", 1, tx);
    check_value("cmd_rdy", 1, cmd_rdy);
    check_value("read_rdy", 0, read_rdy);
    check_value("read_err", 0, read_err);
    report_test("reset state", errs);

    errs = error_count;
    repeat (NUM_WRITES)
    begin
      r = $random(seed);
      c = r[15:0];
      c.write = 1'b1;
      do_command(c, 8'h00, 1'b0, 1'b0, gap);
    end
    report_test("random writes", errs);

    errs = error_count;
    r = $random(seed);
    c = r[15:0];
    c.write = 1'b1;
    do_command(c, 8'h00, 1'b0, 1'b0, gap);
    check_value("tx gap cycles", GAP, gap);
    report_test("frame gap", errs);

    errs = error_count;
    repeat (NUM_READS)
    begin
      r = $random(seed);
      c = r[15:0];
      c.write = 1'b0;
      do_command(c, r[23:16], 1'b0, 1'b0, gap);
    end
    report_test("random reads", errs);

    errs = error_count;
    r = $random(seed);
    c = r[15:0];
    c.write = 1'b0;
    do_command(c, r[23:16], 1'b1, 1'b0, gap);
    report_test("corrupted reply", errs);

    errs = error_count;
    r = $random(seed);
    c = r[15:0];
    c.write = 1'b1;
    do_command(c, 8'h00, 1'b0, 1'b1, gap);
    report_test("ignored command", errs);

    $display("%0d checks, %0d failed", check_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+rtl
+incdir+verif
rtl/uart_cmd_pkg.sv
rtl/uart_tx_serializer.sv
rtl/uart_rx_deserializer.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
verif/tb_uart_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Short bit and gap times keep the run quick
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    -DUART_CMD_DEFINES_SVH \
    -DUART_CLKS_PER_BIT=8 \
    -DUART_GAP_CYCLES=20 \
    -DUART_FRAME_BITS=11 \
    --top-module tb_uart_cmd \
    -f sources.f &&
  ./obj_dir/Vtb_uart_cmd | tee /dev/stderr | grep "Everything OK" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
